// File: files.f
hdl/lar_cfg_pkg.sv
hdl/lar_op_pkg.sv
hdl/lar_wb_master.sv
hdl/lar_metadata.sv
hdl/lar_shared_slot.sv
hdl/lar_slot_select.sv
hdl/lar_write_ctrl.sv
hdl/lar_file_top.sv
tb/lar_file_props.sv
tb/lar_file_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= lar_file_tb
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing --assert
BUILD_FLAGS ?= --binary -j 0
SIM_ARGS ?= +verilator+error+limit+100
PASS_TEXT ?= NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# pass only when the exact pass line shows up in the output
sim:
	$(VERILATOR) $(BUILD_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/lar_file_tb.sv
`default_nettype none

module lar_file_tb
	import lar_cfg_pkg::*;
	import lar_op_pkg::*;
();

	localparam int NUM_LARS = 16;
	localparam int IDX_W = $clog2(NUM_LARS);
	localparam int IDLE_TIMEOUT = 40;

	// lar 2 sits in the same line as lar 1
	localparam addr_t ADDR_L1 = 32'h0000_1230;
	localparam addr_t ADDR_L2 = 32'h0000_1234;
	localparam addr_t ADDR_OLD = 32'h0000_8000;
	localparam addr_t ADDR_NEW = 32'h0001_0008;
	localparam addr_t ADDR_STORE = 32'h0002_0010;
	localparam lar_data_t DATA_SHARED = 64'hdead_beef_0123_4567;
	localparam lar_data_t DATA_OLD = 64'h0f1e_2d3c_4b5a_6978;

	logic clk;
	logic reset_i;
	logic wr_req_i;
	wr_op_e wr_op_i;
	logic [IDX_W-1:0] wr_index_i;
	lar_data_t wr_data_i;
	addr_t wr_addr_i;
	logic [IDX_W-1:0] rd_a_index_i;
	logic [IDX_W-1:0] rd_b_index_i;
	lar_data_t rd_a_data_o;
	addr_t rd_a_addr_o;
	logic [IDX_W-1:0] rd_a_tag_o;
	lar_data_t rd_b_data_o;
	addr_t rd_b_addr_o;
	logic [IDX_W-1:0] rd_b_tag_o;
	logic busy_o;
	logic wb_cyc_o;
	logic wb_stb_o;
	logic wb_we_o;
	base_addr_t wb_adr_o;
	lar_data_t wb_dat_o;
	lar_data_t wb_dat_i;
	logic wb_ack_i;

	// slave model state and transaction record
	logic [31:0] rng_state;
	lar_data_t mem_store [base_addr_t];
	logic log_we [$];
	base_addr_t log_adr [$];
	lar_data_t log_dat [$];

	// read port samples
	lar_data_t a_data;
	addr_t a_addr;
	logic [IDX_W-1:0] a_tag;
	lar_data_t b_data;
	addr_t b_addr;
	logic [IDX_W-1:0] b_tag;
	logic [IDX_W-1:0] tag_first;

	lar_file_top #(
		.NUM_LARS(NUM_LARS)
	) u_lar_file_top (.*);

	always #4 clk = ~clk;

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// line address without the byte offset
	function automatic base_addr_t line_of(input addr_t addr);
		return addr[31:3];
	endfunction

	// unwritten memory returns the line address next to its inverse
	function automatic lar_data_t memory_value(input base_addr_t b);
		return {3'b000, b, 3'b000, ~b};
	endfunction

	task automatic stop_with_error(input string why);
		$display("%s at time %0t", why, $time);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic expect_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp)
		else
		begin
			$display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	endtask

	task automatic wait_until_idle();
		int waited;
		waited = 0;
		while (busy_o)
		begin
			if (waited == IDLE_TIMEOUT)
			begin
				stop_with_error("busy_o never fell after a write");
			end
			@(posedge clk);
			#1;
			waited++;
		end
	endtask

	// one request accepted at the next edge
	task automatic issue_write(input wr_op_e op, input int idx, input addr_t addr,
		input lar_data_t data);
		wr_req_i = 1'b1;
		wr_op_i = op;
		wr_index_i = IDX_W'(idx);
		wr_addr_i = addr;
		wr_data_i = data;
		@(posedge clk);
		#1;
		wr_req_i = 1'b0;
	endtask

	// outputs follow one edge after the index
	task automatic read_lars(input int idx_a, input int idx_b);
		rd_a_index_i = IDX_W'(idx_a);
		rd_b_index_i = IDX_W'(idx_b);
		@(posedge clk);
		#1;
		a_data = rd_a_data_o;
		a_addr = rd_a_addr_o;
		a_tag = rd_a_tag_o;
		b_data = rd_b_data_o;
		b_addr = rd_b_addr_o;
		b_tag = rd_b_tag_o;
	endtask

	task automatic expect_no_bus(input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			expect_value("wb_cyc_o", 64'(wb_cyc_o), 64'd0);
			@(posedge clk);
			#1;
		end
		expect_value("bus transactions", 64'(log_adr.size()), 64'd0);
	endtask

	task automatic clear_bus_log();
		log_we.delete();
		log_adr.delete();
		log_dat.delete();
	endtask

	// wishbone slave that acks after 1 to 3 cycles
	initial
	begin : slave_model
		int wait_left;
		logic active;
		wb_ack_i = 1'b0;
		wb_dat_i = '0;
		rng_state = 32'h568f181d;
		active = 1'b0;
		wait_left = 0;
		forever
		begin
			@(posedge clk);
			#1;
			if (wb_ack_i)
			begin
				// master ended the cycle on this edge
				wb_ack_i = 1'b0;
			end
			else if (wb_cyc_o && wb_stb_o)
			begin
				if (!active)
				begin
					rng_state = next_random(rng_state);
					wait_left = 1 + int'(rng_state % 3);
					active = 1'b1;
				end
				wait_left--;
				if (wait_left == 0)
				begin
					active = 1'b0;
					wb_ack_i = 1'b1;
					log_we.push_back(wb_we_o);
					log_adr.push_back(wb_adr_o);
					log_dat.push_back(wb_dat_o);
					if (wb_we_o)
						mem_store[wb_adr_o] = wb_dat_o;
					else if (mem_store.exists(wb_adr_o))
						wb_dat_i = mem_store[wb_adr_o];
					else
						wb_dat_i = memory_value(wb_adr_o);
				end
			end
		end
	end

	always @(posedge clk)
	begin
		if (u_lar_file_top.u_props.prop_failed)
			stop_with_error("a bus or busy property of the DUT failed");
	end

	initial
	begin
		clk = 1'b0;
		reset_i = 1'b1;
		wr_req_i = 1'b0;
		wr_op_i = WR_DATA;
		wr_index_i = '0;
		wr_data_i = '0;
		wr_addr_i = '0;
		rd_a_index_i = '0;
		rd_b_index_i = '0;
		repeat (4) @(posedge clk);
		#1;
		reset_i = 1'b0;

		// everything empty after reset
		expect_value("busy_o", 64'(busy_o), 64'd0);
		expect_value("wb_cyc_o", 64'(wb_cyc_o), 64'd0);
		for (int i = 0; i < NUM_LARS; i++)
		begin
			read_lars(i, NUM_LARS - 1 - i);
			expect_value($sformatf("rd_a_tag_o lar %0d", i), 64'(a_tag), 64'd0);
			expect_value($sformatf("rd_a_data_o lar %0d", i), a_data, 64'd0);
			expect_value($sformatf("rd_a_addr_o lar %0d", i), 64'(a_addr), 64'd0);
			expect_value($sformatf("rd_b_tag_o lar %0d", NUM_LARS - 1 - i), 64'(b_tag), 64'd0);
			expect_value($sformatf("rd_b_data_o lar %0d", NUM_LARS - 1 - i), b_data, 64'd0);
			expect_value($sformatf("rd_b_addr_o lar %0d", NUM_LARS - 1 - i), 64'(b_addr), 64'd0);
		end

		// load miss reads the line once
		clear_bus_log();
		issue_write(WR_LOAD, 1, ADDR_L1, '0);
		expect_value("busy_o after load miss", 64'(busy_o), 64'd1);
		wait_until_idle();
		expect_value("bus transactions", 64'(log_adr.size()), 64'd1);
		expect_value("wb_we_o of fetch", 64'(log_we[0]), 64'd0);
		expect_value("wb_adr_o of fetch", 64'(log_adr[0]), 64'(line_of(ADDR_L1)));
		read_lars(1, 0);
		expect_value("rd_a_data_o lar 1", a_data, memory_value(line_of(ADDR_L1)));
		expect_value("rd_a_addr_o lar 1", 64'(a_addr), 64'(ADDR_L1));
		assert (a_tag != '0)
		else stop_with_error("lar 1 holds tag 0 after its load");
		tag_first = a_tag;

		// same line from lar 2 joins the slot
		clear_bus_log();
		issue_write(WR_LOAD, 2, ADDR_L2, '0);
		expect_value("busy_o after load hit", 64'(busy_o), 64'd0);
		expect_no_bus(4);
		read_lars(2, 1);
		expect_value("rd_a_tag_o lar 2", 64'(a_tag), 64'(tag_first));
		expect_value("rd_a_data_o lar 2", a_data, memory_value(line_of(ADDR_L2)));
		expect_value("rd_b_data_o lar 1", b_data, memory_value(line_of(ADDR_L1)));
		expect_value("rd_a_addr_o lar 2", 64'(a_addr), 64'(ADDR_L2));

		// lar 1 sees the data written through lar 2
		issue_write(WR_DATA, 2, '0, DATA_SHARED);
		expect_value("busy_o after data write", 64'(busy_o), 64'd0);
		read_lars(1, 2);
		expect_value("rd_a_data_o lar 1", a_data, DATA_SHARED);
		expect_value("rd_b_data_o lar 2", b_data, DATA_SHARED);

		// dirty line moves with write-back then fetch
		issue_write(WR_LOAD, 3, ADDR_OLD, '0);
		wait_until_idle();
		issue_write(WR_DATA, 3, '0, DATA_OLD);
		clear_bus_log();
		issue_write(WR_LOAD, 3, ADDR_NEW, '0);
		wait_until_idle();
		expect_value("bus transactions", 64'(log_adr.size()), 64'd2);
		expect_value("wb_we_o of write-back", 64'(log_we[0]), 64'd1);
		expect_value("wb_adr_o of write-back", 64'(log_adr[0]), 64'(line_of(ADDR_OLD)));
		expect_value("wb_dat_o of write-back", log_dat[0], DATA_OLD);
		expect_value("wb_we_o of fetch", 64'(log_we[1]), 64'd0);
		expect_value("wb_adr_o of fetch", 64'(log_adr[1]), 64'(line_of(ADDR_NEW)));
		read_lars(3, 0);
		expect_value("rd_a_data_o lar 3", a_data, memory_value(line_of(ADDR_NEW)));
		expect_value("rd_a_addr_o lar 3", 64'(a_addr), 64'(ADDR_NEW));

		// store by a sharer takes a new slot with its data
		clear_bus_log();
		issue_write(WR_STORE, 1, ADDR_STORE, '0);
		expect_value("busy_o after store", 64'(busy_o), 64'd0);
		expect_no_bus(4);
		read_lars(1, 2);
		assert ((a_tag != '0) && (a_tag != tag_first))
		else stop_with_error("lar 1 did not move to a new slot on its store");
		expect_value("rd_a_data_o lar 1", a_data, DATA_SHARED);
		expect_value("rd_a_addr_o lar 1", 64'(a_addr), 64'(ADDR_STORE));
		expect_value("rd_b_tag_o lar 2", 64'(b_tag), 64'(tag_first));
		expect_value("rd_b_data_o lar 2", b_data, DATA_SHARED);
		expect_value("rd_b_addr_o lar 2", 64'(b_addr), 64'(ADDR_L2));

		@(posedge clk);
		#1;
		if (u_lar_file_top.u_props.prop_failed)
		begin
			stop_with_error("a bus or busy property of the DUT failed");
		end
		else
		begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: tb/lar_file_props.sv
`default_nettype none

module lar_file_props
	import lar_cfg_pkg::*;
(
	input logic clk,
	input logic reset_i,
	input logic busy_i,
	input logic cyc_i,
	input logic stb_i,
	input logic we_i,
	input base_addr_t adr_i,
	input lar_data_t dat_i,
	input logic ack_i
);

	// set by any failing property, the testbench watches it
	logic prop_failed = 1'b0;

	// classic single transfers, strobe travels with cycle
	stb_with_cyc: assert property (@(posedge clk) disable iff (reset_i) stb_i == cyc_i)
	else
	begin
		prop_failed = 1'b1;
		$error("wb_stb_o differs from wb_cyc_o");
	end

	// request held steady until the slave acks
	held_until_ack: assert property (@(posedge clk) disable iff (reset_i)
		(cyc_i && !ack_i) |=> cyc_i && $stable(adr_i) && $stable(dat_i) && $stable(we_i))
	else
	begin
		prop_failed = 1'b1;
		$error("bus request changed or dropped before ack");
	end

	// memory traffic only while the controller is busy
	cyc_means_busy: assert property (@(posedge clk) disable iff (reset_i) cyc_i |-> busy_i)
	else
	begin
		prop_failed = 1'b1;
		$error("bus cycle active while busy_o is low");
	end

	idle_after_reset: assert property (@(posedge clk)
		reset_i |=> !busy_i && !cyc_i && !stb_i && !we_i)
	else
	begin
		prop_failed = 1'b1;
		$error("controller or bus not idle after reset");
	end

endmodule

bind lar_file_top lar_file_props u_props (
	.clk(clk),
	.reset_i(reset_i),
	.busy_i(busy_o),
	.cyc_i(wb_cyc_o),
	.stb_i(wb_stb_o),
	.we_i(wb_we_o),
	.adr_i(wb_adr_o),
	.dat_i(wb_dat_o),
	.ack_i(wb_ack_i)
);

`default_nettype wire

// File: hdl/lar_file_top.sv
`default_nettype none

module lar_file_top
	import lar_cfg_pkg::*;
	import lar_op_pkg::*;
#(
	parameter int NUM_LARS = 16,
	localparam int IDX_W = $clog2(NUM_LARS)
) (
	input logic clk,
	input logic reset_i,

	// write port
	input logic wr_req_i,
	input wr_op_e wr_op_i,
	input logic [IDX_W-1:0] wr_index_i,
	input lar_data_t wr_data_i,
	input addr_t wr_addr_i,

	// read ports
	input logic [IDX_W-1:0] rd_a_index_i,
	input logic [IDX_W-1:0] rd_b_index_i,
	output lar_data_t rd_a_data_o,
	output addr_t rd_a_addr_o,
	output logic [IDX_W-1:0] rd_a_tag_o,
	output lar_data_t rd_b_data_o,
	output addr_t rd_b_addr_o,
	output logic [IDX_W-1:0] rd_b_tag_o,

	output logic busy_o,

	// wishbone classic master
	output logic wb_cyc_o,
	output logic wb_stb_o,
	output logic wb_we_o,
	output base_addr_t wb_adr_o,
	output lar_data_t wb_dat_o,
	input lar_data_t wb_dat_i,
	input logic wb_ack_i
);

	// per-slot state, tag 0 has no slot
	logic [NUM_LARS-1:1] slot_hit;
	logic [NUM_LARS-1:1] slot_dirty;
	base_addr_t slot_base [1:NUM_LARS-1];
	lar_data_t slot_data [1:NUM_LARS-1];
	ref_cnt_t slot_ref [1:NUM_LARS-1];

	// slot currently held by the written lar
	logic [IDX_W-1:0] alias_tag;
	logic [IDX_W-1:0] cur_tag;
	ref_cnt_t cur_ref;
	logic cur_dirty;
	base_addr_t cur_base;
	lar_data_t cur_data;

	// metadata write and read-side tags
	logic meta_we;
	logic [IDX_W-1:0] meta_index;
	addr_t meta_addr;
	logic [IDX_W-1:0] meta_tag;
	logic [IDX_W-1:0] rd_a_tag_m;
	logic [IDX_W-1:0] rd_b_tag_m;

	// slot command channels
	slot_cmd_e cmd_a;
	logic [IDX_W-1:0] tag_a;
	lar_data_t data_a;
	slot_cmd_e cmd_b;
	logic [IDX_W-1:0] tag_b;
	lar_data_t data_b;
	base_addr_t base_b;

	// bus master handshake
	logic mem_start;
	logic mem_we;
	base_addr_t mem_adr;
	lar_data_t mem_dat;
	logic mem_done;
	lar_data_t mem_rdata;

	lar_write_ctrl #(
		.NUM_LARS(NUM_LARS)
	) u_write_ctrl (
		.clk(clk),
		.reset_i(reset_i),
		.wr_req_i(wr_req_i),
		.wr_op_i(wr_op_i),
		.wr_index_i(wr_index_i),
		.wr_data_i(wr_data_i),
		.wr_addr_i(wr_addr_i),
		.alias_tag_i(alias_tag),
		.cur_tag_i(cur_tag),
		.cur_ref_i(cur_ref),
		.cur_dirty_i(cur_dirty),
		.cur_base_i(cur_base),
		.cur_data_i(cur_data),
		.mem_done_i(mem_done),
		.mem_rdata_i(mem_rdata),
		.busy_o(busy_o),
		.meta_we_o(meta_we),
		.meta_index_o(meta_index),
		.meta_addr_o(meta_addr),
		.meta_tag_o(meta_tag),
		.cmd_a_o(cmd_a),
		.tag_a_o(tag_a),
		.data_a_o(data_a),
		.cmd_b_o(cmd_b),
		.tag_b_o(tag_b),
		.data_b_o(data_b),
		.base_b_o(base_b),
		.mem_start_o(mem_start),
		.mem_we_o(mem_we),
		.mem_adr_o(mem_adr),
		.mem_dat_o(mem_dat)
	);

	lar_metadata #(
		.NUM_LARS(NUM_LARS)
	) u_metadata (
		.clk(clk),
		.reset_i(reset_i),
		.we_i(meta_we),
		.index_i(meta_index),
		.addr_i(meta_addr),
		.tag_i(meta_tag),
		.wr_index_i(wr_index_i),
		.rd_a_index_i(rd_a_index_i),
		.rd_b_index_i(rd_b_index_i),
		.wr_tag_o(cur_tag),
		.rd_a_tag_o(rd_a_tag_m),
		.rd_b_tag_o(rd_b_tag_m),
		.rd_a_addr_o(rd_a_addr_o),
		.rd_b_addr_o(rd_b_addr_o)
	);

	// one slot per nonzero tag
	for (genvar t = 1; t < NUM_LARS; t++)
	begin : g_slot
		lar_shared_slot #(
			.NUM_LARS(NUM_LARS),
			.SLOT_TAG(t)
		) u_slot (
			.clk(clk),
			.reset_i(reset_i),
			.cmd_a_i(cmd_a),
			.tag_a_i(tag_a),
			.data_a_i(data_a),
			.cmd_b_i(cmd_b),
			.tag_b_i(tag_b),
			.data_b_i(data_b),
			.base_b_i(base_b),
			.probe_base_i(wr_addr_i[ADDR_WIDTH-1:OFFSET_WIDTH]),
			.hit_o(slot_hit[t]),
			.base_o(slot_base[t]),
			.data_o(slot_data[t]),
			.ref_o(slot_ref[t]),
			.dirty_o(slot_dirty[t])
		);
	end

	lar_slot_select #(
		.NUM_LARS(NUM_LARS)
	) u_slot_select (
		.clk(clk),
		.reset_i(reset_i),
		.hit_i(slot_hit),
		.base_i(slot_base),
		.data_i(slot_data),
		.ref_i(slot_ref),
		.dirty_i(slot_dirty),
		.cur_tag_i(cur_tag),
		.rd_a_tag_i(rd_a_tag_m),
		.rd_b_tag_i(rd_b_tag_m),
		.alias_tag_o(alias_tag),
		.cur_ref_o(cur_ref),
		.cur_dirty_o(cur_dirty),
		.cur_base_o(cur_base),
		.cur_data_o(cur_data),
		.rd_a_data_o(rd_a_data_o),
		.rd_b_data_o(rd_b_data_o),
		.rd_a_tag_o(rd_a_tag_o),
		.rd_b_tag_o(rd_b_tag_o)
	);

	lar_wb_master u_wb_master (
		.clk(clk),
		.reset_i(reset_i),
		.start_i(mem_start),
		.we_i(mem_we),
		.adr_i(mem_adr),
		.dat_i(mem_dat),
		.wb_dat_i(wb_dat_i),
		.wb_ack_i(wb_ack_i),
		.done_o(mem_done),
		.rdata_o(mem_rdata),
		.wb_cyc_o(wb_cyc_o),
		.wb_stb_o(wb_stb_o),
		.wb_we_o(wb_we_o),
		.wb_adr_o(wb_adr_o),
		.wb_dat_o(wb_dat_o)
	);

endmodule

`default_nettype wire

// File: hdl/lar_write_ctrl.sv
`default_nettype none

module lar_write_ctrl
	import lar_cfg_pkg::*;
	import lar_op_pkg::*;
#(
	parameter int NUM_LARS = 16,
	localparam int IDX_W = $clog2(NUM_LARS)
) (
	input logic clk,
	input logic reset_i,

	input logic wr_req_i,
	input wr_op_e wr_op_i,
	input logic [IDX_W-1:0] wr_index_i,
	input lar_data_t wr_data_i,
	input addr_t wr_addr_i,

	// lookup results for the written lar
	input logic [IDX_W-1:0] alias_tag_i,
	input logic [IDX_W-1:0] cur_tag_i,
	input ref_cnt_t cur_ref_i,
	input logic cur_dirty_i,
	input base_addr_t cur_base_i,
	input lar_data_t cur_data_i,

	input logic mem_done_i,
	input lar_data_t mem_rdata_i,

	output logic busy_o,

	output logic meta_we_o,
	output logic [IDX_W-1:0] meta_index_o,
	output addr_t meta_addr_o,
	output logic [IDX_W-1:0] meta_tag_o,

	// channel a acts on the old slot
	output slot_cmd_e cmd_a_o,
	output logic [IDX_W-1:0] tag_a_o,
	output lar_data_t data_a_o,

	// channel b acts on the new slot
	output slot_cmd_e cmd_b_o,
	output logic [IDX_W-1:0] tag_b_o,
	output lar_data_t data_b_o,
	output base_addr_t base_b_o,

	output logic mem_start_o,
	output logic mem_we_o,
	output base_addr_t mem_adr_o,
	output lar_data_t mem_dat_o
);

	localparam int STACK_DEPTH = NUM_LARS - 1;

	ctrl_state_e state_q;

	// free tags, sp_q counts entries in use
	logic [IDX_W-1:0] stack_q [STACK_DEPTH];
	logic [IDX_W-1:0] sp_q;
	logic [IDX_W-1:0] top_tag;

	// pending fetch captured at acceptance
	logic fetch_pend_q;
	logic [IDX_W-1:0] fetch_tag_q;
	base_addr_t fetch_base_q;

	base_addr_t wr_base;
	logic is_store;
	logic accept;
	logic push;
	logic pop;
	logic need_wb;
	logic need_fetch;

	assign wr_base = wr_addr_i[ADDR_WIDTH-1:OFFSET_WIDTH];
	assign is_store = (wr_op_i == WR_STORE);
	assign top_tag = stack_q[sp_q - 1'b1];
	assign busy_o = (state_q != ST_IDLE);

	// metadata always takes the write address as it comes
	assign meta_index_o = wr_index_i;
	assign meta_addr_o = wr_addr_i;

	// old slot is always the one the lar holds now
	assign tag_a_o = cur_tag_i;
	assign data_a_o = wr_data_i;

	// decode one request into slot commands
	always_comb
	begin
		accept = 1'b0;
		meta_we_o = 1'b0;
		meta_tag_o = cur_tag_i;
		cmd_a_o = SLOT_NOP;
		cmd_b_o = SLOT_NOP;
		tag_b_o = alias_tag_i;
		data_b_o = cur_data_i;
		base_b_o = wr_base;
		push = 1'b0;
		pop = 1'b0;
		need_wb = 1'b0;
		need_fetch = 1'b0;

		if ((state_q == ST_FETCH) && mem_done_i)
		begin
			// fill the slot captured at acceptance, clean
			cmd_b_o = SLOT_SET_DATA;
			tag_b_o = fetch_tag_q;
			data_b_o = mem_rdata_i;
		end
		else if ((state_q == ST_IDLE) && wr_req_i && (wr_index_i != '0))
		begin
			accept = 1'b1;
			case (wr_op_i)
			WR_DATA:
			begin
				// unbound lar has nowhere to put data
				if (cur_tag_i != '0)
				begin
					cmd_a_o = SLOT_SET_DATA;
				end
			end

			WR_LOAD, WR_STORE:
			begin
				meta_we_o = 1'b1;
				if (alias_tag_i != '0)
				begin
					// line already resident, join that slot
					meta_tag_o = alias_tag_i;
					if (alias_tag_i != cur_tag_i)
					begin
						// store carries our old data over, dirty
						cmd_b_o = is_store ? SLOT_ALLOC_STORE : SLOT_REF_INC;
						tag_b_o = alias_tag_i;
						if (cur_ref_i == ref_cnt_t'(1))
						begin
							// last user leaves, slot goes back on the stack
							cmd_a_o = SLOT_FREE;
							push = 1'b1;
							need_wb = cur_dirty_i;
						end
						else if (cur_ref_i != '0)
						begin
							cmd_a_o = SLOT_REF_DEC;
						end
					end
				end
				else if (cur_ref_i == ref_cnt_t'(1))
				begin
					// sole owner, move the slot to the new line
					cmd_b_o = is_store ? SLOT_REBASE_STORE : SLOT_REBASE_LOAD;
					tag_b_o = cur_tag_i;
					need_wb = cur_dirty_i;
					need_fetch = !is_store;
				end
				else
				begin
					// shared or unbound, take a fresh slot
					meta_tag_o = top_tag;
					cmd_b_o = is_store ? SLOT_ALLOC_STORE : SLOT_ALLOC_LOAD;
					tag_b_o = top_tag;
					pop = 1'b1;
					need_fetch = !is_store;
					if (cur_ref_i != '0)
					begin
						cmd_a_o = SLOT_REF_DEC;
					end
				end
			end

			default:
			begin
				accept = 1'b0;
			end
			endcase
		end
	end

	// tag stack and memory sequencing
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			state_q <= ST_IDLE;
			sp_q <= IDX_W'(STACK_DEPTH);
			fetch_pend_q <= 1'b0;
			mem_start_o <= 1'b0;
			mem_we_o <= 1'b0;
			// tag 1 ends up on top
			for (int i = 0; i < STACK_DEPTH; i++)
			begin
				stack_q[i] <= IDX_W'(STACK_DEPTH - i);
			end
		end
		else
		begin
			mem_start_o <= 1'b0;

			if (push)
			begin
				stack_q[sp_q] <= cur_tag_i;
				sp_q <= sp_q + 1'b1;
			end
			else if (pop)
			begin
				sp_q <= sp_q - 1'b1;
			end

			case (state_q)
			ST_IDLE:
			begin
				if (accept)
				begin
					fetch_tag_q <= meta_tag_o;
					fetch_base_q <= wr_base;
					fetch_pend_q <= need_fetch;
					if (need_wb)
					begin
						// old line goes out first
						mem_start_o <= 1'b1;
						mem_we_o <= 1'b1;
						mem_adr_o <= cur_base_i;
						mem_dat_o <= cur_data_i;
						state_q <= ST_WRITE_BACK;
					end
					else if (need_fetch)
					begin
						mem_start_o <= 1'b1;
						mem_we_o <= 1'b0;
						mem_adr_o <= wr_base;
						state_q <= ST_FETCH;
					end
				end
			end

			ST_WRITE_BACK:
			begin
				if (mem_done_i)
				begin
					if (fetch_pend_q)
					begin
						mem_start_o <= 1'b1;
						mem_we_o <= 1'b0;
						mem_adr_o <= fetch_base_q;
						state_q <= ST_FETCH;
					end
					else
					begin
						state_q <= ST_IDLE;
					end
				end
			end

			ST_FETCH:
			begin
				// slot fill happens on this same edge
				if (mem_done_i)
				begin
					state_q <= ST_IDLE;
				end
			end

			default:
			begin
				state_q <= ST_IDLE;
			end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/lar_slot_select.sv
`default_nettype none

module lar_slot_select
	import lar_cfg_pkg::*;
#(
	parameter int NUM_LARS = 16,
	localparam int IDX_W = $clog2(NUM_LARS)
) (
	input logic clk,
	input logic reset_i,

	// one entry per slot, tag 0 excluded
	input logic [NUM_LARS-1:1] hit_i,
	input base_addr_t base_i [1:NUM_LARS-1],
	input lar_data_t data_i [1:NUM_LARS-1],
	input ref_cnt_t ref_i [1:NUM_LARS-1],
	input logic [NUM_LARS-1:1] dirty_i,

	input logic [IDX_W-1:0] cur_tag_i,
	input logic [IDX_W-1:0] rd_a_tag_i,
	input logic [IDX_W-1:0] rd_b_tag_i,

	output logic [IDX_W-1:0] alias_tag_o,
	output ref_cnt_t cur_ref_o,
	output logic cur_dirty_o,
	output base_addr_t cur_base_o,
	output lar_data_t cur_data_o,

	output lar_data_t rd_a_data_o,
	output lar_data_t rd_b_data_o,
	output logic [IDX_W-1:0] rd_a_tag_o,
	output logic [IDX_W-1:0] rd_b_tag_o
);

	// tag 0 always reads as zero data
	function automatic lar_data_t data_of(input logic [IDX_W-1:0] tag);
		lar_data_t d;
		d = '0;
		if (tag != '0)
		begin
			d = data_i[tag];
		end
		return d;
	endfunction

	// at most one live slot holds a given line
	always_comb
	begin
		alias_tag_o = '0;
		for (int t = 1; t < NUM_LARS; t++)
		begin
			if (hit_i[t])
			begin
				alias_tag_o = IDX_W'(t);
			end
		end
	end

	// fields of the slot the written lar points at
	always_comb
	begin
		cur_ref_o = '0;
		cur_dirty_o = 1'b0;
		cur_base_o = '0;
		if (cur_tag_i != '0)
		begin
			cur_ref_o = ref_i[cur_tag_i];
			cur_dirty_o = dirty_i[cur_tag_i];
			cur_base_o = base_i[cur_tag_i];
		end
	end

	assign cur_data_o = data_of(cur_tag_i);

	// read ports show the state before this edge
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			rd_a_data_o <= '0;
			rd_b_data_o <= '0;
			rd_a_tag_o <= '0;
			rd_b_tag_o <= '0;
		end
		else
		begin
			rd_a_data_o <= data_of(rd_a_tag_i);
			rd_b_data_o <= data_of(rd_b_tag_i);
			rd_a_tag_o <= rd_a_tag_i;
			rd_b_tag_o <= rd_b_tag_i;
		end
	end

endmodule

`default_nettype wire

// File: hdl/lar_shared_slot.sv
`default_nettype none

module lar_shared_slot
	import lar_cfg_pkg::*;
	import lar_op_pkg::*;
#(
	parameter int NUM_LARS = 16,
	parameter int SLOT_TAG = 1,
	localparam int IDX_W = $clog2(NUM_LARS)
) (
	input logic clk,
	input logic reset_i,

	input slot_cmd_e cmd_a_i,
	input logic [IDX_W-1:0] tag_a_i,
	input lar_data_t data_a_i,

	input slot_cmd_e cmd_b_i,
	input logic [IDX_W-1:0] tag_b_i,
	input lar_data_t data_b_i,
	input base_addr_t base_b_i,

	// line address of the incoming write
	input base_addr_t probe_base_i,

	output logic hit_o,
	output base_addr_t base_o,
	output lar_data_t data_o,
	output ref_cnt_t ref_o,
	output logic dirty_o
);

	logic sel_a;
	logic sel_b;

	base_addr_t base_q;
	lar_data_t data_q;
	ref_cnt_t ref_q;
	logic dirty_q;

	assign sel_a = (tag_a_i == IDX_W'(SLOT_TAG));
	assign sel_b = (tag_b_i == IDX_W'(SLOT_TAG));

	// a free slot never aliases
	assign hit_o = (ref_q != '0) && (base_q == probe_base_i);

	assign base_o = base_q;
	assign data_o = data_q;
	assign ref_o = ref_q;
	assign dirty_o = dirty_q;

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			ref_q <= '0;
			dirty_q <= 1'b0;
		end
		else
		begin
			// old slot side
			if (sel_a)
			begin
				case (cmd_a_i)
				SLOT_SET_DATA:
				begin
					// only a real change needs a write-back later
					if (data_q != data_a_i)
					begin
						dirty_q <= 1'b1;
					end
					data_q <= data_a_i;
				end
				SLOT_REF_DEC:
				begin
					ref_q <= ref_q - 1'b1;
				end
				SLOT_FREE:
				begin
					ref_q <= '0;
					dirty_q <= 1'b0;
				end
				default:
				begin
				end
				endcase
			end

			// new slot side, never the same slot as channel a
			if (sel_b)
			begin
				case (cmd_b_i)
				SLOT_SET_DATA:
				begin
					// fetch fill matches memory
					data_q <= data_b_i;
					dirty_q <= 1'b0;
				end
				SLOT_REF_INC:
				begin
					ref_q <= ref_q + 1'b1;
				end
				SLOT_ALLOC_LOAD:
				begin
					// adds one user, a popped slot starts at zero
					ref_q <= ref_q + 1'b1;
					base_q <= base_b_i;
					dirty_q <= 1'b0;
				end
				SLOT_ALLOC_STORE:
				begin
					// also used when a store joins a resident line
					ref_q <= ref_q + 1'b1;
					base_q <= base_b_i;
					data_q <= data_b_i;
					dirty_q <= 1'b1;
				end
				SLOT_REBASE_LOAD:
				begin
					base_q <= base_b_i;
					dirty_q <= 1'b0;
				end
				SLOT_REBASE_STORE:
				begin
					// data stays, now owed to the new line
					base_q <= base_b_i;
					dirty_q <= 1'b1;
				end
				default:
				begin
				end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/lar_metadata.sv
`default_nettype none

module lar_metadata
	import lar_cfg_pkg::*;
#(
	parameter int NUM_LARS = 16,
	localparam int IDX_W = $clog2(NUM_LARS)
) (
	input logic clk,
	input logic reset_i,

	input logic we_i,
	input logic [IDX_W-1:0] index_i,
	input addr_t addr_i,
	input logic [IDX_W-1:0] tag_i,

	input logic [IDX_W-1:0] wr_index_i,
	input logic [IDX_W-1:0] rd_a_index_i,
	input logic [IDX_W-1:0] rd_b_index_i,

	output logic [IDX_W-1:0] wr_tag_o,
	output logic [IDX_W-1:0] rd_a_tag_o,
	output logic [IDX_W-1:0] rd_b_tag_o,
	output addr_t rd_a_addr_o,
	output addr_t rd_b_addr_o
);

	// address and slot tag of every lar
	addr_t addr_q [NUM_LARS];
	logic [IDX_W-1:0] tag_q [NUM_LARS];

	// tags leave unregistered, the selector holds them with the data
	assign wr_tag_o = tag_q[wr_index_i];
	assign rd_a_tag_o = tag_q[rd_a_index_i];
	assign rd_b_tag_o = tag_q[rd_b_index_i];

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			for (int i = 0; i < NUM_LARS; i++)
			begin
				addr_q[i] <= '0;
				tag_q[i] <= '0;
			end
			rd_a_addr_o <= '0;
			rd_b_addr_o <= '0;
		end
		else
		begin
			// lar 0 is never written, the controller filters it
			if (we_i)
			begin
				addr_q[index_i] <= addr_i;
				tag_q[index_i] <= tag_i;
			end
			// address as it stood before this edge
			rd_a_addr_o <= addr_q[rd_a_index_i];
			rd_b_addr_o <= addr_q[rd_b_index_i];
		end
	end

endmodule

`default_nettype wire

// File: hdl/lar_wb_master.sv
`default_nettype none

module lar_wb_master
	import lar_cfg_pkg::*;
(
	input logic clk,
	input logic reset_i,

	// one request per start pulse
	input logic start_i,
	input logic we_i,
	input base_addr_t adr_i,
	input lar_data_t dat_i,

	input lar_data_t wb_dat_i,
	input logic wb_ack_i,

	output logic done_o,
	output lar_data_t rdata_o,

	output logic wb_cyc_o,
	output logic wb_stb_o,
	output logic wb_we_o,
	output base_addr_t wb_adr_o,
	output lar_data_t wb_dat_o
);

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			wb_cyc_o <= 1'b0;
			wb_stb_o <= 1'b0;
			wb_we_o <= 1'b0;
			done_o <= 1'b0;
		end
		else
		begin
			done_o <= 1'b0;
			if (!wb_cyc_o)
			begin
				if (start_i)
				begin
					// address and data held until ack
					wb_cyc_o <= 1'b1;
					wb_stb_o <= 1'b1;
					wb_we_o <= we_i;
					wb_adr_o <= adr_i;
					wb_dat_o <= dat_i;
				end
			end
			else if (wb_ack_i)
			begin
				// cycle ends, done seen one edge later
				wb_cyc_o <= 1'b0;
				wb_stb_o <= 1'b0;
				wb_we_o <= 1'b0;
				done_o <= 1'b1;
				if (!wb_we_o)
				begin
					rdata_o <= wb_dat_i;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/lar_op_pkg.sv
`default_nettype none

package lar_op_pkg;

	// operation carried by a write request
	typedef enum logic [1:0] {
		WR_DATA = 2'd0,
		WR_LOAD = 2'd1,
		WR_STORE = 2'd2
	} wr_op_e;

	// command sent to the shared data slots
	typedef enum logic [3:0] {
		SLOT_NOP = 4'd0,
		SLOT_SET_DATA = 4'd1,
		SLOT_ALLOC_LOAD = 4'd2,
		SLOT_ALLOC_STORE = 4'd3,
		SLOT_REF_INC = 4'd4,
		SLOT_REF_DEC = 4'd5,
		SLOT_FREE = 4'd6,
		SLOT_REBASE_LOAD = 4'd7,
		SLOT_REBASE_STORE = 4'd8
	} slot_cmd_e;

	// memory sequencing FSM of the write controller
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_WRITE_BACK = 2'd1,
		ST_FETCH = 2'd2
	} ctrl_state_e;

endpackage

`default_nettype wire

// File: hdl/lar_cfg_pkg.sv
`default_nettype none

package lar_cfg_pkg;

	// full byte address of a lar
	localparam int ADDR_WIDTH = 32;

	// low address bits that pick a byte inside one 8-byte line
	localparam int OFFSET_WIDTH = 3;

	// line address, also the word address on the bus
	localparam int BASE_WIDTH = ADDR_WIDTH - OFFSET_WIDTH;

	// one shared data word
	localparam int DATA_WIDTH = 64;

	// reference counter width, room for 31 sharers
	localparam int REF_WIDTH = 5;

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [BASE_WIDTH-1:0] base_addr_t;
	typedef logic [DATA_WIDTH-1:0] lar_data_t;
	typedef logic [REF_WIDTH-1:0] ref_cnt_t;

endpackage

`default_nettype wire
